// ==== flist.f ====
src/bin_queue_pkg.sv
src/rr_arbiter.sv
src/queue_scheduler.sv
src/update_binner.sv
src/bin_fifo_array.sv
src/bin_queue_top.sv
bench/tb_bin_queue.sv

// ==== bench/tb_bin_queue.sv ====
// ========================================
// Testbench of the binned update queue
//   Per-bin reference queues
//   Preload, random and quiet phases
//   Assertions on gating, data, order
//   Watchdog on run length
// ========================================
`timescale 1ns/1ps

module tb_bin_queue;
    import bin_queue_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 4;
    localparam int RANDOM_CYCLES   = 300;
    // Upper bound on updates sent over all phases
    localparam int MAX_UPDATES     = 15 + RANDOM_CYCLES + 13;
    localparam int WATCHDOG_CYCLES = MAX_UPDATES * 20 + 2000;
    // Entries younger than this may still be in the binner
    localparam int LATE_CYCLES     = 6;
    localparam int OVF_BIN         = 5;

    logic                       clk_i;
    logic                       rst_i;
    logic                       upd_valid_i;
    update_t                    upd_i;
    logic [PE_NUM_OF_CORES-1:0] init_done_i;
    logic                       rd_valid_o;
    update_t                    rd_data_o;
    logic [BIN_IDX_WIDTH-1:0]   rd_bin_o;
    logic [BIN_NUM-1:0]         bin_selected_o;
    logic                       overflow_o;

    // One reference queue per bin plus drive times
    update_t                    model_q [BIN_NUM][$];
    time                        stamp_q [BIN_NUM][$];

    // Monitor history
    logic [BIN_NUM-1:0]         last_onehot;
    logic [BIN_IDX_WIDTH-1:0]   last_rd_bin;
    int                         prev_sel;
    logic                       rr_armed;
    time                        rr_arm_time;

    bin_queue_top dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .upd_valid_i    (upd_valid_i),
        .upd_i          (upd_i),
        .init_done_i    (init_done_i),
        .rd_valid_o     (rd_valid_o),
        .rd_data_o      (rd_data_o),
        .rd_bin_o       (rd_bin_o),
        .bin_selected_o (bin_selected_o),
        .overflow_o     (overflow_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic update_t make_update(input int b);
        update_t u;
        u.key   = KEY_WIDTH'($urandom);
        u.value = VALUE_WIDTH'($urandom);
        // Top key bits name the bin
        u.key[KEY_WIDTH-1 -: BIN_IDX_WIDTH] = BIN_IDX_WIDTH'(b);
        return u;
    endfunction

    // Drive one update and mirror it in the model
    task automatic send_update(input update_t u);
        int b;
        b = int'(u.key[KEY_WIDTH-1 -: BIN_IDX_WIDTH]);
        @(posedge clk_i);
        upd_valid_i <= 1'b1;
        upd_i       <= u;
        // Full bin drops the write
        if (model_q[b].size() < BIN_DEPTH) begin
            model_q[b].push_back(u);
            stamp_q[b].push_back($time);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            upd_valid_i <= 1'b0;
        end
    endtask

    function automatic bit model_all_empty();
        for (int b = 0; b < BIN_NUM; b++) begin
            if (model_q[b].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // First non-empty bin after prev with wrap
    function automatic int next_rr_bin(input int prev);
        int b;
        for (int i = 1; i <= BIN_NUM; i++) begin
            b = (prev + i) % BIN_NUM;
            if (model_q[b].size() != 0) begin
                return b;
            end
        end
        return -1;
    endfunction

    task automatic wait_drained();
        while (!model_all_empty()) begin
            @(posedge clk_i);
        end
        idle_cycles(4);
    endtask

    task automatic random_traffic(input int cycles);
        update_t u;
        int      b;
        for (int c = 0; c < cycles; c++) begin
            u.key   = KEY_WIDTH'($urandom);
            u.value = VALUE_WIDTH'($urandom);
            b       = int'(u.key[KEY_WIDTH-1 -: BIN_IDX_WIDTH]);
            // Roughly 60 percent load and never into a full bin
            if (($urandom % 10) < 6 && model_q[b].size() < BIN_DEPTH) begin
                send_update(u);
            end else begin
                idle_cycles(1);
            end
        end
    endtask

    // ========================================
    // Assertions
    // ========================================

    // Nothing leaves the queue before every core is done
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(&init_done_i) |-> (!rd_valid_o && bin_selected_o == '0))
    else report_failure("read data or bin selection active before all cores finished init");

    // Sticky until reset
    assert property (@(posedge clk_i) disable iff (rst_i) overflow_o |=> overflow_o)
    else report_failure("overflow flag fell after it had been set");

    // Sampled mid-cycle away from the driving edge
    always @(negedge clk_i) begin : monitor
        update_t exp_upd;
        int      exp_bin;
        if (!rst_i) begin
            if (bin_selected_o != '0) begin
                assert (bin_selected_o == (BIN_NUM'(1) << rd_bin_o))
                else report_failure($sformatf("mismatch bin_selected_o: got %h expected %h",
                                              bin_selected_o, BIN_NUM'(1) << rd_bin_o));
            end
            // Data against the front of the drained bin
            if (rd_valid_o) begin
                assert (model_q[rd_bin_o].size() != 0) begin
                    exp_upd = model_q[rd_bin_o].pop_front();
                    void'(stamp_q[rd_bin_o].pop_front());
                    assert (rd_data_o == exp_upd)
                    else report_failure($sformatf("mismatch rd_data_o: got %h expected %h",
                                                  rd_data_o, exp_upd));
                end else begin
                    report_failure($sformatf("read from bin %0d which holds no entry",
                                             rd_bin_o));
                end
            end
            // Previous bin may keep only entries still in flight
            if (last_onehot != '0 && rd_bin_o != last_rd_bin &&
                stamp_q[last_rd_bin].size() != 0) begin
                assert ($time - stamp_q[last_rd_bin][0] <= LATE_CYCLES * CLK_PERIOD)
                else report_failure($sformatf("bin %0d left undrained when bin %0d was picked",
                                              last_rd_bin, rd_bin_o));
            end
            // New pick
            if (bin_selected_o != last_onehot && bin_selected_o != '0) begin
                if (rr_armed && $time >= rr_arm_time) begin
                    exp_bin = next_rr_bin(prev_sel);
                    assert (int'(rd_bin_o) == exp_bin)
                    else report_failure($sformatf("mismatch rd_bin_o: got %h expected %h",
                                                  rd_bin_o, exp_bin));
                end
                prev_sel = int'(rd_bin_o);
            end
            last_onehot = bin_selected_o;
            last_rd_bin = rd_bin_o;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        report_failure($sformatf("run timed out after %0d cycles", WATCHDOG_CYCLES));
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin : main
        void'($urandom(2465));
        rst_i       = 1'b1;
        upd_valid_i = 1'b0;
        upd_i       = '0;
        init_done_i = '0;
        last_onehot = '0;
        last_rd_bin = '0;
        // Search starts at bin 0
        prev_sel    = BIN_NUM - 1;
        rr_armed    = 1'b0;
        rr_arm_time = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        assert (!overflow_o && !rd_valid_o && bin_selected_o == '0)
        else report_failure("outputs not idle after reset");

        // Preload before init with one bin filled to the brim
        for (int i = 0; i < BIN_DEPTH; i++) begin
            send_update(make_update(OVF_BIN));
        end
        send_update(make_update(1));
        send_update(make_update(1));
        send_update(make_update(6));
        send_update(make_update(6));
        send_update(make_update(6));
        send_update(make_update(3));
        idle_cycles(4);
        @(negedge clk_i);
        assert (overflow_o == 1'b0)
        else report_failure($sformatf("mismatch overflow_o: got %h expected %h", overflow_o, 0));
        // Ninth write to a full bin
        send_update(make_update(OVF_BIN));
        idle_cycles(4);
        @(negedge clk_i);
        assert (overflow_o == 1'b1)
        else report_failure($sformatf("mismatch overflow_o: got %h expected %h", overflow_o, 1));
        idle_cycles(1);
        rr_armed    = 1'b1;
        rr_arm_time = $time;

        // Cores finish one at a time
        for (int c = 0; c < PE_NUM_OF_CORES; c++) begin
            idle_cycles(6);
            @(posedge clk_i);
            init_done_i[c] <= 1'b1;
        end
        wait_drained();

        // Random traffic with writes into bins while they drain
        rr_armed = 1'b0;
        random_traffic(RANDOM_CYCLES);
        idle_cycles(1);
        wait_drained();

        // Quiet reload where later picks follow round-robin
        for (int i = 0; i < BIN_DEPTH; i++) begin
            send_update(make_update(4));
        end
        send_update(make_update(6));
        send_update(make_update(6));
        send_update(make_update(0));
        send_update(make_update(0));
        send_update(make_update(2));
        idle_cycles(1);
        rr_arm_time = $time + 4 * CLK_PERIOD;
        rr_armed    = 1'b1;
        wait_drained();
        idle_cycles(10);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src/bin_queue_top.sv ====
// ========================================
// Binned update queue top level
//   Binner into the bin FIFO array
//   Scheduler drains one bin at a time
// ========================================
`timescale 1ns/1ps

module bin_queue_top (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      upd_valid_i,
    input  bin_queue_pkg::update_t                    upd_i,
    input  logic [bin_queue_pkg::PE_NUM_OF_CORES-1:0] init_done_i,
    output logic                                      rd_valid_o,
    output bin_queue_pkg::update_t                    rd_data_o,
    output logic [bin_queue_pkg::BIN_IDX_WIDTH-1:0]   rd_bin_o,
    output logic [bin_queue_pkg::BIN_NUM-1:0]         bin_selected_o,
    output logic                                      overflow_o
);
    import bin_queue_pkg::*;

    // Binner outputs
    bin_wr_t                  bin_wr;
    logic [BIN_NUM-1:0]       cu_clean;

    // FIFO status
    logic [BIN_NUM-1:0]       bin_valid;

    // Scheduler control
    logic                     read_en;
    logic [BIN_IDX_WIDTH-1:0] sel_bin;

    // Bin being drained
    assign rd_bin_o = sel_bin;

    update_binner u_update_binner (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i),
        .bin_wr_o    (bin_wr),
        .cu_clean_o  (cu_clean)
    );

    bin_fifo_array u_bin_fifo_array (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bin_wr_i    (bin_wr),
        .read_en_i   (read_en),
        .sel_bin_i   (sel_bin),
        .bin_valid_o (bin_valid),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o),
        .overflow_o  (overflow_o)
    );

    queue_scheduler u_queue_scheduler (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .init_done_i    (init_done_i),
        .cu_clean_i     (cu_clean),
        .bin_valid_i    (bin_valid),
        .bin_selected_o (bin_selected_o),
        .sel_bin_o      (sel_bin),
        .read_en_o      (read_en)
    );

endmodule

// ==== src/bin_fifo_array.sv ====
// ========================================
// Array of per-bin FIFOs
//   Circular buffers with own pointers
//   Non-empty flags per bin
//   Registered read port of selected bin
//   Sticky overflow on write to full bin
// ========================================
`timescale 1ns/1ps

module bin_fifo_array (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  bin_queue_pkg::bin_wr_t                  bin_wr_i,
    input  logic                                    read_en_i,
    input  logic [bin_queue_pkg::BIN_IDX_WIDTH-1:0] sel_bin_i,
    output logic [bin_queue_pkg::BIN_NUM-1:0]       bin_valid_o,
    output logic                                    rd_valid_o,
    output bin_queue_pkg::update_t                  rd_data_o,
    output logic                                    overflow_o
);
    import bin_queue_pkg::*;

    // Entry storage
    update_t                  mem    [BIN_NUM][BIN_DEPTH];

    // Per-bin bookkeeping
    logic [BIN_PTR_WIDTH-1:0] wr_ptr [BIN_NUM];
    logic [BIN_PTR_WIDTH-1:0] rd_ptr [BIN_NUM];
    logic [BIN_CNT_WIDTH-1:0] count  [BIN_NUM];

    logic                     wr_full;
    logic                     do_wr;
    logic                     do_rd;
    logic [BIN_NUM-1:0]       wr_hit;
    logic [BIN_NUM-1:0]       rd_hit;

    // Write dropped when target bin is full
    assign wr_full = (count[bin_wr_i.bin] == BIN_CNT_WIDTH'(BIN_DEPTH));
    assign do_wr   = bin_wr_i.valid && !wr_full;
    // Pop only from a non-empty selected bin
    assign do_rd   = read_en_i && bin_valid_o[sel_bin_i];

    always_comb begin
        for (int b = 0; b < BIN_NUM; b++) begin
            bin_valid_o[b] = (count[b] != '0);
            wr_hit[b]      = do_wr && (bin_wr_i.bin == BIN_IDX_WIDTH'(b));
            rd_hit[b]      = do_rd && (sel_bin_i == BIN_IDX_WIDTH'(b));
        end
    end

    // ======================================
    // Storage and pointers
    // ======================================

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[bin_wr_i.bin][wr_ptr[bin_wr_i.bin]] <= bin_wr_i.upd;
        end
    end

    // Same-bin write and pop in one cycle leave count unchanged
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                wr_ptr[b] <= '0;
                rd_ptr[b] <= '0;
                count[b]  <= '0;
            end
        end else begin
            for (int b = 0; b < BIN_NUM; b++) begin
                if (wr_hit[b]) begin
                    wr_ptr[b] <= wr_ptr[b] + 1'b1;
                end
                if (rd_hit[b]) begin
                    rd_ptr[b] <= rd_ptr[b] + 1'b1;
                end
                if (wr_hit[b] && !rd_hit[b]) begin
                    count[b] <= count[b] + 1'b1;
                end else if (rd_hit[b] && !wr_hit[b]) begin
                    count[b] <= count[b] - 1'b1;
                end
            end
        end
    end

    // ======================================
    // Read port and overflow
    // ======================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= do_rd;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_rd) begin
            rd_data_o <= mem[sel_bin_i][rd_ptr[sel_bin_i]];
        end
    end

    // Held until reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            overflow_o <= 1'b0;
        end else if (bin_wr_i.valid && wr_full) begin
            overflow_o <= 1'b1;
        end
    end

endmodule

// ==== src/update_binner.sv ====
// ========================================
// Two-stage update binner
//   Stage 1 holds the raw update
//   Stage 2 holds update plus bin index
//   Per-bin clean flags from both stages
// ========================================
`timescale 1ns/1ps

module update_binner (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              upd_valid_i,
    input  bin_queue_pkg::update_t            upd_i,
    output bin_queue_pkg::bin_wr_t            bin_wr_o,
    output logic [bin_queue_pkg::BIN_NUM-1:0] cu_clean_o
);
    import bin_queue_pkg::*;

    // Stage 1
    logic                     s1_valid;
    update_t                  s1_upd;
    logic [BIN_IDX_WIDTH-1:0] s1_bin;

    // Stage 2
    logic                     s2_valid;
    logic [BIN_IDX_WIDTH-1:0] s2_bin;
    update_t                  s2_upd;

    // Bin is the top key bits
    assign s1_bin = s1_upd.key[KEY_WIDTH-1 -: BIN_IDX_WIDTH];

    // ======================================
    // Pipeline
    // ======================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= upd_valid_i;
            s2_valid <= s1_valid;
        end
    end

    // Payload only loads behind a valid
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            s1_upd <= upd_i;
        end
        if (s1_valid) begin
            s2_upd <= s1_upd;
            s2_bin <= s1_bin;
        end
    end

    // Stage 2 feeds the FIFO write port directly
    always_comb begin
        bin_wr_o.valid = s2_valid;
        bin_wr_o.bin   = s2_bin;
        bin_wr_o.upd   = s2_upd;
    end

    // ======================================
    // Clean flags
    // ======================================

    // Low while either stage carries an update for the bin
    always_comb begin
        for (int b = 0; b < BIN_NUM; b++) begin
            cu_clean_o[b] = !((s1_valid && s1_bin == BIN_IDX_WIDTH'(b)) ||
                              (s2_valid && s2_bin == BIN_IDX_WIDTH'(b)));
        end
    end

endmodule

// ==== src/queue_scheduler.sv ====
// ========================================
// Queue scheduler
//   Waits for all cores to finish init
//   Picks a bin by round robin
//   Waits for the bin to be clean
//   Holds read enable until it is empty
// ========================================
`timescale 1ns/1ps

module queue_scheduler (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic [bin_queue_pkg::PE_NUM_OF_CORES-1:0] init_done_i,
    input  logic [bin_queue_pkg::BIN_NUM-1:0]         cu_clean_i,
    input  logic [bin_queue_pkg::BIN_NUM-1:0]         bin_valid_i,
    output logic [bin_queue_pkg::BIN_NUM-1:0]         bin_selected_o,
    output logic [bin_queue_pkg::BIN_IDX_WIDTH-1:0]   sel_bin_o,
    output logic                                      read_en_o
);
    import bin_queue_pkg::*;

    qs_state_e                state;
    qs_state_e                next_state;

    // Arbiter side
    logic [BIN_NUM-1:0]       arb_req;
    logic [BIN_IDX_WIDTH-1:0] grant;
    logic [BIN_NUM-1:0]       grant_onehot;
    logic                     grant_valid;
    logic                     grant_ack;

    // Status of the selected bin
    logic                     all_init_done;
    logic                     sel_clean;
    logic                     sel_nonempty;

    assign all_init_done = &init_done_i;
    assign sel_clean     = cu_clean_i[sel_bin_o];
    assign sel_nonempty  = bin_valid_i[sel_bin_o];

    // During bind only the latched bin requests
    // so the ack moves the pointer past that bin
    assign arb_req = (state == QS_BIND) ? bin_selected_o : bin_valid_i;

    rr_arbiter u_rr_arbiter (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .ack_i          (grant_ack),
        .req_i          (arb_req),
        .grant_o        (grant),
        .grant_onehot_o (grant_onehot),
        .valid_o        (grant_valid)
    );

    // ======================================
    // FSM
    // ======================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= QS_INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            QS_INIT: begin
                if (all_init_done) begin
                    next_state = QS_CHOOSE;
                end
            end
            QS_CHOOSE: begin
                if (bin_valid_i != '0) begin
                    next_state = QS_BIND;
                end
            end
            // Single cycle
            QS_BIND: next_state = QS_WAIT;
            QS_WAIT: begin
                if (sel_clean) begin
                    next_state = QS_READ;
                end
            end
            QS_READ: begin
                if (!sel_nonempty) begin
                    next_state = QS_CHOOSE;
                end
            end
            default: next_state = QS_INIT;
        endcase
    end

    // ======================================
    // Outputs
    // ======================================

    // Ack is high exactly while in bind
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_ack <= 1'b0;
        end else begin
            grant_ack <= (next_state == QS_BIND);
        end
    end

    // Set on the clean edge and cleared on the empty edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            read_en_o <= 1'b0;
        end else if (state == QS_WAIT && sel_clean) begin
            read_en_o <= 1'b1;
        end else if (state == QS_READ && !sel_nonempty) begin
            read_en_o <= 1'b0;
        end
    end

    // Latch the grant when leaving choose
    // Kept until the next pick
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sel_bin_o      <= '0;
            bin_selected_o <= '0;
        end else if (state == QS_CHOOSE && grant_valid) begin
            sel_bin_o      <= grant;
            bin_selected_o <= grant_onehot;
        end
    end

endmodule

// ==== src/rr_arbiter.sv ====
// ========================================
// Round-robin arbiter over the bins
//   Search from a rotating priority pointer
//   Pointer moves past the grant on ack
// ========================================
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  ack_i,
    input  logic [bin_queue_pkg::BIN_NUM-1:0]       req_i,
    output logic [bin_queue_pkg::BIN_IDX_WIDTH-1:0] grant_o,
    output logic [bin_queue_pkg::BIN_NUM-1:0]       grant_onehot_o,
    output logic                                  valid_o
);
    import bin_queue_pkg::*;

    // Highest priority requester
    logic [BIN_IDX_WIDTH-1:0] prio_ptr;

    // ======================================
    // Grant search
    // ======================================

    // First request at or after the pointer
    always_comb begin
        int unsigned idx;
        grant_o = '0;
        valid_o = 1'b0;
        for (int i = 0; i < BIN_NUM; i++) begin
            // Wrap past the last bin
            idx = (int'(prio_ptr) + i) % BIN_NUM;
            if (!valid_o && req_i[idx]) begin
                valid_o = 1'b1;
                grant_o = BIN_IDX_WIDTH'(idx);
            end
        end
    end

    // One-hot copy of the grant
    always_comb begin
        grant_onehot_o = '0;
        if (valid_o) begin
            grant_onehot_o[grant_o] = 1'b1;
        end
    end

    // ======================================
    // Priority pointer
    // ======================================

    // Granted bin drops to lowest priority
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio_ptr <= '0;
        end else if (ack_i && valid_o) begin
            if (grant_o == BIN_IDX_WIDTH'(BIN_NUM - 1)) begin
                prio_ptr <= '0;
            end else begin
                prio_ptr <= grant_o + 1'b1;
            end
        end
    end

endmodule

// ==== src/bin_queue_pkg.sv ====
// ========================================
// Shared definitions of the binned queue
//   Core count and bin geometry
//   Update and bin-write structs
//   Scheduler state encoding
// ========================================
package bin_queue_pkg;

    // Cores reporting end of initial phase
    localparam int PE_NUM_OF_CORES = 4;

    // Bin geometry
    localparam int BIN_NUM       = 8;
    localparam int BIN_IDX_WIDTH = 3;
    localparam int BIN_DEPTH     = 8;
    localparam int BIN_PTR_WIDTH = $clog2(BIN_DEPTH);
    // Count runs 0 to BIN_DEPTH so one extra bit
    localparam int BIN_CNT_WIDTH = $clog2(BIN_DEPTH + 1);

    // Update fields
    localparam int KEY_WIDTH   = 16;
    localparam int VALUE_WIDTH = 16;

    // Update as streamed by the cores
    // Top BIN_IDX_WIDTH key bits pick the bin
    typedef struct packed {
        logic [KEY_WIDTH-1:0]   key;
        logic [VALUE_WIDTH-1:0] value;
    } update_t;

    // Binner to FIFO array write
    typedef struct packed {
        logic                     valid;
        logic [BIN_IDX_WIDTH-1:0] bin;
        update_t                  upd;
    } bin_wr_t;

    // Scheduler states
    typedef enum logic [2:0] {
        QS_INIT,    // Waiting on all cores
        QS_CHOOSE,  // Looking for a non-empty bin
        QS_BIND,    // Ack to the arbiter
        QS_WAIT,    // Bin still has updates in flight
        QS_READ     // Draining
    } qs_state_e;

endpackage
